/* design/dac_pkg.sv */
`default_nettype none

package dac_pkg;

	////////////////////////////////////////////////////////////
	// Levels
	////////////////////////////////////////////////////////////

	// One DAC code, 12 bits
	typedef logic [11:0] level_t;

	// Full scale
	localparam level_t LEVEL_MAX = 12'd4095;

	////////////////////////////////////////////////////////////
	// DAC command and address fields
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		CMD_WRITE        = 4'd0,
		CMD_UPDATE       = 4'd1,
		CMD_WRITE_UPDATE = 4'd3,
		CMD_POWER_DOWN   = 4'd4
	} dac_cmd_e;

	typedef enum logic [3:0] {
		ADDR_A   = 4'd0,
		ADDR_B   = 4'd1,
		ADDR_C   = 4'd2,
		ADDR_D   = 4'd3,
		ADDR_ALL = 4'd15
	} dac_addr_e;

	// SPI frame, MSB goes out first
	typedef struct packed {
		logic [7:0] pad_hi;
		dac_cmd_e   cmd;
		dac_addr_e  addr;
		level_t     level;
		logic [3:0] pad_lo;
	} dac_frame_t;

	// One-cycle press strobes
	typedef struct packed {
		logic less;
		logic more;
	} btn_strobe_t;

endpackage

`default_nettype wire

/* design/button_strobe.sv */
`timescale 1ns/10ps
`default_nettype none

module button_strobe
	import dac_pkg::*;
(
	input  wire         CLK50MHZ,
	input  wire         RST,
	input  wire         less,
	input  wire         more,
	output btn_strobe_t btn
);

	// Bit 1 is less, bit 0 is more
	logic [1:0] sync_a;
	logic [1:0] sync_b;
	logic [1:0] prev;
	logic [1:0] rise;

	// Low to high on the synchronized inputs
	assign rise = sync_b & ~prev;

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			sync_a   <= 2'b00;
			sync_b   <= 2'b00;
			prev     <= 2'b00;
			btn.less <= 1'b0;
			btn.more <= 1'b0;
		end else begin
			// Two flops against metastability
			sync_a <= {less, more};
			sync_b <= sync_a;
			prev   <= sync_b;
			// Less beats more on a tie
			btn.less <= rise[1];
			btn.more <= rise[0] & ~rise[1];
		end
	end

endmodule

`default_nettype wire

/* design/dac_level_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_level_ctrl
	import dac_pkg::*;
#(
	parameter int STEP = 32
) (
	input  wire         CLK50MHZ,
	input  wire         RST,
	input  btn_strobe_t btn,
	input  wire  [3:0]  sw,
	input  wire         busy,
	input  wire         done,
	input  wire  [31:0] rx_word,
	output dac_frame_t  frame,
	output logic        start,
	output logic [7:0]  led
);

	// One extra bit so the upward sum can exceed full scale
	localparam logic [12:0] STEP_W = 13'(STEP);

	level_t      level;
	level_t      level_next;
	logic [12:0] level_up;
	logic [7:0]  step_cnt;
	logic [7:0]  cnt_next;
	logic        pending;
	logic        strobe;
	logic        ready;
	logic        launch;
	logic [7:0]  rb_byte;

	////////////////////////////////////////////////////////////
	// Level step and clamp
	////////////////////////////////////////////////////////////

	always_comb begin
		level_up   = {1'b0, level} + STEP_W;
		level_next = level;
		cnt_next   = step_cnt;
		if (btn.less) begin
			if ({1'b0, level} >= STEP_W) begin
				level_next = level - STEP_W[11:0];
				cnt_next   = step_cnt - 8'd1;
			end else begin
				// Clamped at bottom, count untouched
				level_next = '0;
			end
		end else if (btn.more) begin
			if (level_up <= {1'b0, LEVEL_MAX}) begin
				level_next = level_up[11:0];
				cnt_next   = step_cnt + 8'd1;
			end else begin
				level_next = LEVEL_MAX;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Frame requests
	////////////////////////////////////////////////////////////

	assign strobe = btn.less | btn.more;
	// Link free, or finishing this very cycle
	assign ready  = (~busy & ~start) | done;
	assign launch = (strobe | pending) & ready;

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			level    <= '0;
			step_cnt <= 8'd0;
			pending  <= 1'b0;
			start    <= 1'b0;
		end else begin
			level    <= level_next;
			step_cnt <= cnt_next;
			start    <= launch;
			// Presses during a transfer merge into one frame
			if (launch)
				pending <= 1'b0;
			else if (strobe)
				pending <= 1'b1;
		end
	end

	// Held until the next launch, so stable through the transfer
	always_ff @(posedge CLK50MHZ) begin
		if (launch) begin
			frame.pad_hi <= 8'h00;
			frame.cmd    <= CMD_WRITE_UPDATE;
			frame.addr   <= ADDR_ALL;
			frame.level  <= level_next;
			frame.pad_lo <= 4'h0;
		end
	end

	////////////////////////////////////////////////////////////
	// LEDs
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			rb_byte <= 8'h00;
		end else begin
			case (sw)
				4'b1000: rb_byte <= rx_word[31:24];
				4'b0100: rb_byte <= rx_word[23:16];
				4'b0010: rb_byte <= rx_word[15:8];
				4'b0001: rb_byte <= rx_word[7:0];
				// Not one-hot, keep last byte
				default: rb_byte <= rb_byte;
			endcase
		end
	end

	assign led = (sw == 4'b0000) ? step_cnt : rb_byte;

endmodule

`default_nettype wire

/* design/dac_spi_link.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_spi_link
	import dac_pkg::*;
#(
	parameter int SCK_DIV = 2
) (
	input  wire         CLK50MHZ,
	input  wire         RST,
	input  dac_frame_t  frame,
	input  wire         start,
	output logic        busy,
	output logic        done,
	output logic [31:0] rx_word,
	output logic        spi_sck,
	output logic        spi_mosi,
	output logic        spi_cs_n,
	input  wire         spi_miso
);

	// Wide enough for SCK_DIV of 1 as well
	localparam int DIV_W = $clog2(SCK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCK_DIV - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_FINISH
	} state_e;

	state_e           state;
	logic [DIV_W-1:0] div_cnt;
	logic [4:0]       bit_cnt;
	logic [31:0]      tx_sr;
	logic [31:0]      rx_sr;

	// Top bit always on the wire
	assign spi_mosi = tx_sr[31];

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= ST_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= 5'd0;
			busy     <= 1'b0;
			done     <= 1'b0;
			spi_sck  <= 1'b0;
			spi_cs_n <= 1'b1;
			rx_word  <= 32'h0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					busy <= start;
					if (start) begin
						state    <= ST_SHIFT;
						spi_cs_n <= 1'b0;
						div_cnt  <= '0;
						bit_cnt  <= 5'd0;
					end
				end
				ST_SHIFT: begin
					if (div_cnt == DIV_LAST) begin
						div_cnt <= '0;
						spi_sck <= ~spi_sck;
						// Falling SCK ends a bit
						if (spi_sck && bit_cnt == 5'd31) begin
							state    <= ST_FINISH;
							spi_cs_n <= 1'b1;
						end else if (spi_sck) begin
							bit_cnt <= bit_cnt + 5'd1;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				ST_FINISH: begin
					// One cycle after CS release
					done    <= 1'b1;
					rx_word <= rx_sr;
					state   <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Shift registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_IDLE && start) begin
			tx_sr <= frame;
		end else if (state == ST_SHIFT && div_cnt == DIV_LAST) begin
			if (!spi_sck)
				rx_sr <= {rx_sr[30:0], spi_miso};  // SCK about to rise
			else
				tx_sr <= {tx_sr[30:0], 1'b0};       // next bit while SCK low
		end
	end

endmodule

`default_nettype wire

/* design/dac_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_top
	import dac_pkg::*;
#(
	parameter int STEP    = 32,
	parameter int SCK_DIV = 2
) (
	input  wire        CLK50MHZ,
	input  wire        RST,
	input  wire        less,
	input  wire        more,
	input  wire  [3:0] sw,
	input  wire        spi_miso,
	output logic       spi_sck,
	output logic       spi_mosi,
	output logic       spi_cs_n,
	output logic [7:0] led
);

	btn_strobe_t btn;
	dac_frame_t  frame;
	logic        start;
	logic        busy;
	logic        done;
	logic [31:0] rx_word;

	// Raw buttons to press strobes
	button_strobe btn_i (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.less     (less),
		.more     (more),
		.btn      (btn)
	);

	// Level, step count and LEDs
	dac_level_ctrl #(
		.STEP (STEP)
	) ctrl_i (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.btn      (btn),
		.sw       (sw),
		.busy     (busy),
		.done     (done),
		.rx_word  (rx_word),
		.frame    (frame),
		.start    (start),
		.led      (led)
	);

	// Serial link to the DAC
	dac_spi_link #(
		.SCK_DIV (SCK_DIV)
	) spi_i (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.frame    (frame),
		.start    (start),
		.busy     (busy),
		.done     (done),
		.rx_word  (rx_word),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.spi_miso (spi_miso)
	);

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int RESET_CYCLES = 4
) (
	output logic CLK50MHZ,
	output logic RST
);

	// 50 MHz, 20 ns period
	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	// Released 2 ns after an edge, same as the stimulus
	initial begin
		RST = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK50MHZ);
		#2;
		RST = 1'b0;
	end

endmodule

`default_nettype wire

/* test/tb_dac_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dac_top
	import dac_pkg::*;
();

	localparam int STEP             = 32;
	localparam int DIRECTED_PRESSES = 263;
	localparam int RANDOM_PRESSES   = 40;
	localparam int FRAME_WAIT       = 400;
	// Roughly 200 cycles per press plus slack
	localparam int MAX_CYCLES = (DIRECTED_PRESSES + RANDOM_PRESSES) * 200 + 2000;
	// Release, done and the next start take 3 clock periods
	localparam int MIN_CS_HIGH = 3 * 20;

	logic        CLK50MHZ;
	logic        RST;
	logic        less;
	logic        more;
	logic [3:0]  sw;
	logic        spi_miso;
	logic        spi_sck;
	logic        spi_mosi;
	logic        spi_cs_n;
	logic [7:0]  led;

	// DAC shift register and frame log
	logic [31:0] model_sr = 32'h0;
	dac_frame_t  rec_frame;
	logic [31:0] frames[$];
	int unsigned frame_count = 0;
	time         cs_rise_time = 0;
	int unsigned sck_total = 0;
	int unsigned sck_at_cs = 0;
	int unsigned cycles = 0;
	// Reference model
	int          model_level;
	logic [7:0]  model_count;
	logic [31:0] last_word;
	logic [31:0] prev_word;
	int          seed;

	tb_clock_gen clk_i (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST)
	);

	dac_top #(
		.STEP    (STEP),
		.SCK_DIV (2)
	) dut_i (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.less     (less),
		.more     (more),
		.sw       (sw),
		.spi_miso (spi_miso),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.led      (led)
	);

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string what);
		$display("ERROR %s", what);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	// Watchdog
	always @(posedge CLK50MHZ) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("ERROR run exceeded %0d cycles without finishing", MAX_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// DAC model that echoes the previous frame on MISO
	////////////////////////////////////////////////////////////

	assign spi_miso = model_sr[31];

	always @(posedge spi_sck) begin
		model_sr  <= {model_sr[30:0], spi_mosi};
		sck_total = sck_total + 1;
	end

	// CS stays high through done and the next start
	always @(negedge spi_cs_n) begin
		if (!RST) begin
			assert (frame_count == 0 || $time - cs_rise_time >= MIN_CS_HIGH)
				else report_error("chip select fell while a transfer was in progress");
			sck_at_cs = sck_total;
		end
	end

	// Check the fixed fields of a finished frame and log it
	always @(posedge spi_cs_n) begin
		if (!RST) begin
			rec_frame    = dac_frame_t'(model_sr);
			cs_rise_time = $time;
			assert (sck_total - sck_at_cs == 32)
				else report_mismatch("bits per frame", 32'd32, 32'(sck_total - sck_at_cs));
			assert (rec_frame.pad_hi == 8'h00)
				else report_mismatch("frame pad_hi", 32'h0, 32'(rec_frame.pad_hi));
			assert (rec_frame.cmd == 4'd3)
				else report_mismatch("frame command", 32'd3, 32'(rec_frame.cmd));
			assert (rec_frame.addr == 4'd15)
				else report_mismatch("frame address", 32'd15, 32'(rec_frame.addr));
			assert (rec_frame.pad_lo == 4'h0)
				else report_mismatch("frame pad_lo", 32'h0, 32'(rec_frame.pad_lo));
			frames.push_back(model_sr);
			frame_count = frame_count + 1;
		end
	end

	// SCK parked low whenever CS is released
	sck_idle_a: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_cs_n |-> !spi_sck)
		else report_error("SCK high while chip select was released");

	// MOSI only moves while SCK is low
	mosi_setup_a: assert property (@(posedge CLK50MHZ) disable iff (RST)
		(!spi_cs_n && $changed(spi_mosi)) |-> !spi_sck)
		else report_error("MOSI changed while SCK was high");

	////////////////////////////////////////////////////////////
	// Reference model and stimulus
	////////////////////////////////////////////////////////////

	// Write and update to all channels
	function automatic logic [31:0] frame_word(input int lvl);
		return {8'h00, 4'd3, 4'd15, lvl[11:0], 4'h0};
	endfunction

	task automatic apply_press(input logic up);
		if (!up) begin
			if (model_level >= STEP) begin
				model_level = model_level - STEP;
				model_count = model_count - 8'd1;
			end else begin
				model_level = 0;
			end
		end else if (model_level + STEP <= 4095) begin
			model_level = model_level + STEP;
			model_count = model_count + 8'd1;
		end else begin
			model_level = 4095;
		end
	endtask

	// Held 6 cycles and released 6
	task automatic press(input logic up);
		@(posedge CLK50MHZ);
		#2;
		less = ~up;
		more = up;
		repeat (6) @(posedge CLK50MHZ);
		#2;
		less = 1'b0;
		more = 1'b0;
		apply_press(up);
		repeat (5) @(posedge CLK50MHZ);
	endtask

	task automatic wait_frames(input int unsigned want);
		int unsigned waited;
		waited = 0;
		while (frame_count < want && waited < FRAME_WAIT) begin
			@(posedge CLK50MHZ);
			waited++;
		end
		if (frame_count < want)
			report_error("no SPI frame completed after a press");
		// Done and rx_word follow CS release
		repeat (3) @(posedge CLK50MHZ);
	endtask

	task automatic check_readback(input string name);
		int i;
		int b;
		// Bytes 3, 0, 1 then 2, so the command and address byte is shown last
		for (i = 0; i < 4; i++) begin
			b = (i + 3) % 4;
			@(posedge CLK50MHZ);
			#2;
			sw = 4'(1 << b);
			repeat (2) @(posedge CLK50MHZ);
			#1;
			assert (led == prev_word[8*b +: 8])
				else report_mismatch({name, " readback byte"}, 32'(prev_word[8*b +: 8]),
					32'(led));
		end
		// Non-one-hot setting holds the last byte shown
		@(posedge CLK50MHZ);
		#2;
		sw = 4'b0110;
		repeat (2) @(posedge CLK50MHZ);
		#1;
		assert (led == prev_word[23:16])
			else report_mismatch({name, " held byte"}, 32'(prev_word[23:16]), 32'(led));
		@(posedge CLK50MHZ);
		#2;
		sw = 4'b0000;
		#1;
		assert (led == model_count)
			else report_mismatch({name, " step count"}, 32'(model_count), 32'(led));
	endtask

	task automatic press_and_check(input logic up, input string name);
		int unsigned want;
		want = frame_count + 1;
		press(up);
		wait_frames(want);
		prev_word = last_word;
		last_word = frame_word(model_level);
		assert (frames[$] == last_word)
			else report_mismatch({name, " frame"}, last_word, frames[$]);
		check_readback(name);
	endtask

	// Pending frames leave CS high only a few cycles
	task automatic wait_quiet();
		int unsigned quiet;
		int unsigned waited;
		quiet  = 0;
		waited = 0;
		while (quiet < 40 && waited < 2000) begin
			@(posedge CLK50MHZ);
			waited++;
			if (spi_cs_n)
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < 40)
			report_error("SPI link did not go idle after the random presses");
	endtask

	initial begin
		logic [31:0] rnd;
		less        = 1'b0;
		more        = 1'b0;
		sw          = 4'b0000;
		model_level = 0;
		model_count = 8'd0;
		last_word   = 32'h0;
		prev_word   = 32'h0;
		seed        = 76;
		repeat (2) @(posedge CLK50MHZ);
		wait (RST == 1'b0);
		repeat (20) @(posedge CLK50MHZ);
		#1;

		// Reset state with no frame yet
		assert (spi_cs_n == 1'b1) else report_mismatch("reset cs_n", 32'd1, 32'(spi_cs_n));
		assert (spi_sck == 1'b0) else report_mismatch("reset sck", 32'd0, 32'(spi_sck));
		assert (led == 8'd0) else report_mismatch("reset led", 32'd0, 32'(led));
		assert (frame_count == 0) else report_error("a frame was sent before any press");
		check_readback("reset");

		// Bottom clamp then up to full scale and back
		repeat (2) press_and_check(1'b0, "clamp_low_start");
		repeat (130) press_and_check(1'b1, "climb");
		assert (frames[$][15:4] == 12'd4095)
			else report_mismatch("top clamp", 32'd4095, 32'(frames[$][15:4]));
		repeat (131) press_and_check(1'b0, "descend");
		assert (frames[$][15:4] == 12'd0)
			else report_mismatch("bottom clamp", 32'd0, 32'(frames[$][15:4]));

		// Random presses with about half landing mid-transfer
		repeat (RANDOM_PRESSES) begin
			rnd = $random(seed);
			press(rnd[0]);
			if (rnd[4])
				repeat (rnd[14:8]) @(posedge CLK50MHZ);
		end
		wait_quiet();
		#1;
		assert (frames[$] == frame_word(model_level))
			else report_mismatch("random final frame", frame_word(model_level), frames[$]);
		assert (led == model_count)
			else report_mismatch("random step count", 32'(model_count), 32'(led));

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
design/dac_pkg.sv
design/button_strobe.sv
design/dac_level_ctrl.sv
design/dac_spi_link.sv
design/dac_top.sv
test/tb_clock_gen.sv
test/tb_dac_top.sv

/* Makefile */
# Verilator build and run for the DAC testbench

VERILATOR ?= verilator
TOP       ?= tb_dac_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS PASS_MSG"

# Pass only when the pass message shows up in the output
test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
